/* rv_stim.txt */
# kind addr word: I = program word, D = data word, S = expected store
# ADDI/ADD/SUB/AND/OR/XOR, stores, loads, JAL with a skipped SW
I 000 12300093
I 010 FAA00113
I 020 002081B3
I 030 40208233
I 040 0020F2B3
I 050 0020E333
I 060 0020C3B3
I 070 10302023
I 080 10402223
I 090 10502423
I 0A0 10602623
I 0B0 10702823
I 0C0 20002403
I 0D0 20402483
I 0E0 10802A23
I 0F0 10902C23
I 100 00940533
I 110 10A02E23
I 120 020005EF
I 124 1E102823
I 150 12B02023
D 200 CAFEF00D
D 204 13572468
S 100 000000CD
S 104 00000179
S 108 00000122
S 10C FFFFFFAB
S 110 FFFFFE89
S 114 CAFEF00D
S 118 13572468
S 11C DE561475
S 120 00000124

/* project.f */
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_fetch_decode.sv
rv_execute_writeback.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core -f project.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

/* tb_rv_core.sv */
`timescale 1ns/100ps
`include "rv_consts.svh"

module tb_rv_core
    import rv_pkg::*;
();

    logic                clk;
    logic                rst_n;
    logic                halt;
    logic [`RV_XLEN-1:0] imem_data;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] dmem_rdata;
    rv_dmem_req_t        dmem_req;

    logic [31:0] imem [256];          // 0x000..0x3fc
    logic [31:0] dmem [16384];        // full 16-bit data space
    logic [15:0] exp_addr [$];        // expected stores in order
    logic [31:0] exp_data [$];
    int          n_prog_words;        // I records in the stim file
    int          stores_seen;
    logic        loaded;
    logic        run_en;
    logic [31:0] lfsr;
    logic        bit_a;
    logic        bit_b;

    rv_core uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt       (halt),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    // *******************************************************************
    // memory models
    // *******************************************************************

    assign imem_data  = (imem_addr < 32'd1024) ? imem[imem_addr[9:2]] : `RV_NOP;
    assign dmem_rdata = dmem[dmem_req.addr[15:2]];

    always @(posedge clk) begin
        if (rst_n && !dmem_req.read_wrn)
            dmem[dmem_req.addr[15:2]] <= dmem_req.wdata;   // store commit
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_dmem_req(input string name, input rv_dmem_req_t got,
                                  input rv_dmem_req_t exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s = %h/%h/%h, expected %h/%h/%h", name,
                     got.read_wrn, got.addr, got.wdata, exp.read_wrn, exp.addr, exp.wdata));
    endtask

    task automatic check_addr(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
    endtask

    // records "I addr word", "D addr word" and "S addr data" with # comment lines
    task automatic load_stim();
        int          fd;
        int          code;
        byte         kind;
        logic [31:0] a;
        logic [31:0] w;
        string       line;
        fd = $fopen("rv_stim.txt", "r");
        if (fd == 0)
            fail_run("cannot open the stimulus file rv_stim.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
                break;
            if (kind == "#") begin
                void'($fgets(line, fd));         // skip comment line
            end else begin
                code = $fscanf(fd, "%h %h", a, w);
                if (code != 2)
                    fail_run("malformed record in the stimulus file");
                case (kind)
                    "I": begin
                        imem[a[9:2]] = w;
                        n_prog_words++;
                    end
                    "D": dmem[a[15:2]] <= w;     // lands after the fill
                    "S": begin
                        exp_addr.push_back(a[15:0]);
                        exp_data.push_back(w);
                    end
                    default: fail_run("unknown record type in the stimulus file");
                endcase
            end
        end
        $fclose(fd);
    endtask

    // *******************************************************************
    // halt source and store monitor
    // *******************************************************************

    always @(negedge clk) begin
        if (run_en) begin
            lfsr  = lfsr_step(lfsr);
            bit_a = lfsr[0];
            lfsr  = lfsr_step(lfsr);
            bit_b = lfsr[0];
            halt  = bit_a & bit_b;              // roughly one cycle in four
            // a store counts once on the edge that moves it on
            if (!dmem_req.read_wrn && !halt) begin
                if (stores_seen >= exp_addr.size())
                    fail_run("a store appeared on the data bus that the program must skip");
                check_dmem_req("dmem_req", dmem_req,
                               '{read_wrn: 1'b0, addr: exp_addr[stores_seen],
                                 wdata: exp_data[stores_seen]});
                stores_seen++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_prog_words * 40 + 200) @(posedge clk);
        fail_run("timeout, the expected stores did not all appear");
    end

    // *******************************************************************
    // main sequence
    // *******************************************************************

    initial begin
        logic [15:0] a16;
        rst_n        = 1'b0;
        halt         = 1'b0;
        run_en       = 1'b0;
        loaded       = 1'b0;
        n_prog_words = 0;
        stores_seen  = 0;
        lfsr         = 32'h6bd5;
        for (int i = 0; i < 256; i++)
            imem[i] = {4'h0, i[7:0], 13'h0, 7'h13};   // ADDI x0, x0, index
        for (int i = 0; i < 16384; i++) begin
            a16     = 16'(i * 4);
            dmem[i] <= {~a16, a16};
        end
        load_stim();
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_addr("imem_addr", imem_addr, `RV_RESET_PC);
        check_dmem_req("dmem_req", dmem_req, '{read_wrn: 1'b1, addr: '0, wdata: '0});
        @(posedge clk);
        run_en = 1'b1;

        wait (stores_seen == exp_addr.size());
        repeat (30) @(negedge clk);              // catch a late extra store
        for (int i = 0; i < exp_addr.size(); i++)
            check_word($sformatf("dmem[%h]", exp_addr[i]),
                       dmem[exp_addr[i][15:2]], exp_data[i]);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* rv_core_assert.sv */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core_assert
    import rv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 halt,
    input  logic [`RV_XLEN-1:0]  imem_addr,
    input  rv_dmem_req_t         dmem_req
);

    // a store needs the pipeline to have run 3 edges out of reset
    store_after_reset: assert property (@(posedge clk)
        !dmem_req.read_wrn |-> (rst_n && $past(rst_n, 3)))
        else $error("store presented too soon after reset");

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

    // frozen edge leaves both buses untouched
    halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
        $past(halt) |-> ($stable(imem_addr) && $stable(dmem_req)))
        else $error("bus changed across a halted cycle");

    read_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> dmem_req.read_wrn)
        else $error("data bus not idle when reset ends");

endmodule

bind rv_core rv_core_assert u_core_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .halt      (halt),
    .imem_addr (imem_addr),
    .dmem_req  (dmem_req)
);

/* rv_core.sv */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 halt,          // freezes every pipeline register
    input  logic [`RV_XLEN-1:0]  imem_data,     // word at imem_addr, same cycle
    output logic [`RV_XLEN-1:0]  imem_addr,
    output rv_dmem_req_t         dmem_req,
    input  logic [`RV_XLEN-1:0]  dmem_rdata     // data at dmem_req.addr, same cycle
);

    logic [`RV_REG_AW-1:0] rs1_idx;
    logic [`RV_REG_AW-1:0] rs2_idx;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    rv_id_ex_t             id_ex;          // decode -> execute
    rv_wb_t                wb;             // write-back -> regfile

    // fetch, decode, ID/EX
    rv_fetch_decode u_fetch_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .halt      (halt),
        .imem_data (imem_data),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imem_addr (imem_addr),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .id_ex     (id_ex)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .halt     (halt),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // ALU, EX/MEM, data bus, MEM/WB
    rv_execute_writeback u_execute_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt       (halt),
        .id_ex      (id_ex),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .wb         (wb)
    );

endmodule

/* rv_execute_writeback.sv */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_execute_writeback
    import rv_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 halt,
    input  rv_id_ex_t            id_ex,
    input  logic [`RV_XLEN-1:0]  dmem_rdata,
    output rv_dmem_req_t         dmem_req,
    output rv_wb_t               wb
);

    logic [`RV_XLEN-1:0]   alu_result;

    // EX/MEM
    logic [`RV_XLEN-1:0]   ex_result;       // ALU out, also data address
    rv_mem_op_e            ex_mem_op;
    logic [`RV_XLEN-1:0]   ex_store_data;
    logic [`RV_REG_AW-1:0] ex_rd;
    logic                  ex_wb_en;
    logic                  ex_wb_from_alu;

    // *******************************************************************
    // execute
    // *******************************************************************

    always_comb begin
        case (id_ex.alu_op)
            ADD:     alu_result = id_ex.operand_a + id_ex.operand_b;
            SUB:     alu_result = id_ex.operand_a - id_ex.operand_b;
            AND:     alu_result = id_ex.operand_a & id_ex.operand_b;
            OR:      alu_result = id_ex.operand_a | id_ex.operand_b;
            XOR:     alu_result = id_ex.operand_a ^ id_ex.operand_b;
            PASS_B:  alu_result = id_ex.operand_b;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_result      <= '0;
            ex_mem_op      <= MEM_NONE;
            ex_store_data  <= '0;
            ex_rd          <= '0;
            ex_wb_en       <= 1'b0;
            ex_wb_from_alu <= 1'b0;
        end else if (!halt) begin
            ex_result      <= alu_result;
            ex_mem_op      <= id_ex.mem_op;
            ex_store_data  <= id_ex.store_data;
            ex_rd          <= id_ex.rd;
            ex_wb_en       <= id_ex.wb_en;
            ex_wb_from_alu <= id_ex.wb_from_alu;
        end
    end

    // *******************************************************************
    // memory access
    // *******************************************************************

    always_comb begin
        dmem_req.read_wrn = 1'b1;           // idle reads with zeros
        dmem_req.addr     = '0;
        dmem_req.wdata    = '0;
        case (ex_mem_op)
            MEM_LOAD: begin
                dmem_req.addr     = ex_result[`RV_DADDR_W-1:0];
            end
            MEM_STORE: begin
                dmem_req.read_wrn = 1'b0;   // memory commits at next edge
                dmem_req.addr     = ex_result[`RV_DADDR_W-1:0];
                dmem_req.wdata    = ex_store_data;
            end
            default: ;
        endcase
    end

    // *******************************************************************
    // write-back
    // *******************************************************************

    // MEM/WB, regfile writes it one edge later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!halt) begin
            wb.wb_en <= ex_wb_en;
            wb.rd    <= ex_rd;
            wb.data  <= ex_wb_from_alu ? ex_result : dmem_rdata;  // load data otherwise
        end
    end

endmodule

/* rv_fetch_decode.sv */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_fetch_decode
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   halt,
    input  logic [`RV_XLEN-1:0]    imem_data,
    input  logic [`RV_XLEN-1:0]    rs1_data,
    input  logic [`RV_XLEN-1:0]    rs2_data,
    output logic [`RV_XLEN-1:0]    imem_addr,
    output logic [`RV_REG_AW-1:0]  rs1_idx,
    output logic [`RV_REG_AW-1:0]  rs2_idx,
    output rv_id_ex_t              id_ex
);

    logic [`RV_XLEN-1:0]   pc;            // fetch address
    logic [`RV_XLEN-1:0]   ir;            // instruction register
    logic [`RV_XLEN-1:0]   ir_pc;         // address of the word in ir
    logic [`RV_XLEN-1:0]   pc_next;
    logic [`RV_XLEN-1:0]   ir_next;
    logic                  jal_taken;

    rv_opcode_e            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm_i;
    logic [`RV_XLEN-1:0]   imm_s;
    logic [`RV_XLEN-1:0]   imm_j;
    rv_alu_op_e            r_alu_op;      // R-type op from funct fields
    logic                  r_valid;
    rv_id_ex_t             uop;           // decode result, into id_ex

    // bubble micro-op, no write-back, no memory access
    function automatic rv_id_ex_t nop_uop();
        rv_id_ex_t u;
        u        = '0;
        u.alu_op = PASS_B;
        u.mem_op = MEM_NONE;
        return u;
    endfunction

    // *******************************************************************
    // fetch
    // *******************************************************************

    assign imem_addr = pc;
    assign jal_taken = (opcode == JAL);  // jump sits in ir this cycle

    always_comb begin
        if (jal_taken) begin
            pc_next = ir_pc + imm_j;       // redirect to jump target
            ir_next = `RV_NOP;             // squash word fetched behind it
        end else begin
            pc_next = pc + 32'd4;
            ir_next = imem_data;
        end
    end

    // *******************************************************************
    // field extraction
    // *******************************************************************

    assign opcode  = rv_opcode_e'(ir[6:0]);
    assign rd      = ir[11:7];
    assign funct3  = ir[14:12];
    assign rs1_idx = ir[19:15];
    assign rs2_idx = ir[24:20];
    assign funct7  = ir[31:25];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    // R-type funct7/funct3 pairs
    always_comb begin
        r_valid  = 1'b1;
        r_alu_op = ADD;
        case ({funct7, funct3})
            10'b0000000_000: r_alu_op = ADD;
            10'b0100000_000: r_alu_op = SUB;
            10'b0000000_100: r_alu_op = XOR;
            10'b0000000_110: r_alu_op = OR;
            10'b0000000_111: r_alu_op = AND;
            default:         r_valid  = 1'b0;  // unsupported, bubble
        endcase
    end

    // *******************************************************************
    // decode
    // *******************************************************************

    always_comb begin
        uop = nop_uop();
        case (opcode)
            OP_IMM: if (funct3 == 3'b000) begin    // ADDI
                uop.alu_op      = ADD;
                uop.operand_a   = rs1_data;
                uop.operand_b   = imm_i;
                uop.rd          = rd;
                uop.wb_en       = (rd != '0);
                uop.wb_from_alu = 1'b1;
            end
            OP: if (r_valid) begin
                uop.alu_op      = r_alu_op;
                uop.operand_a   = rs1_data;
                uop.operand_b   = rs2_data;
                uop.rd          = rd;
                uop.wb_en       = (rd != '0);
                uop.wb_from_alu = 1'b1;
            end
            LOAD: if (funct3 == 3'b010) begin      // LW
                uop.alu_op      = ADD;             // address = rs1 + imm
                uop.operand_a   = rs1_data;
                uop.operand_b   = imm_i;
                uop.mem_op      = MEM_LOAD;
                uop.rd          = rd;
                uop.wb_en       = (rd != '0);
                uop.wb_from_alu = 1'b0;
            end
            STORE: if (funct3 == 3'b010) begin     // SW
                uop.alu_op      = ADD;
                uop.operand_a   = rs1_data;
                uop.operand_b   = imm_s;
                uop.mem_op      = MEM_STORE;
                uop.store_data  = rs2_data;
            end
            JAL: begin
                uop.alu_op      = ADD;             // link = pc + 4
                uop.operand_a   = ir_pc;
                uop.operand_b   = 32'd4;
                uop.rd          = rd;
                uop.wb_en       = (rd != '0);
                uop.wb_from_alu = 1'b1;
            end
            default: ;                             // bubble
        endcase
    end

    // pc, ir and ID/EX all freeze on halt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= `RV_RESET_PC;
            ir    <= `RV_NOP;
            ir_pc <= `RV_RESET_PC;
            id_ex <= nop_uop();
        end else if (!halt) begin
            pc    <= pc_next;
            ir    <= ir_next;
            ir_pc <= pc;
            id_ex <= uop;
        end
    end

endmodule

/* rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_consts.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   halt,
    input  logic [`RV_REG_AW-1:0]  rs1_idx,
    input  logic [`RV_REG_AW-1:0]  rs2_idx,
    input  rv_wb_t                 wb,
    output logic [`RV_XLEN-1:0]    rs1_data,
    output logic [`RV_XLEN-1:0]    rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // one read port, x0 hard zero, pending write seen straight away
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] idx);
        if (idx == '0)
            return '0;
        else if (wb.wb_en && (wb.rd == idx))
            return wb.data;                // write-through
        else
            return regs[idx];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (!halt && wb.wb_en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;        // x0 never written
        end
    end

endmodule

/* rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b001_0011,   // ADDI only
        OP     = 7'b011_0011,   // register-register ALU ops
        LOAD   = 7'b000_0011,   // LW only
        STORE  = 7'b010_0011,   // SW only
        JAL    = 7'b110_1111
    } rv_opcode_e;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_B = 3'd5           // result = operand_b
    } rv_alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } rv_mem_op_e;

    // decoded micro-op, registered between decode and execute
    typedef struct packed {
        rv_alu_op_e                alu_op;
        logic [`RV_XLEN-1:0]       operand_a;
        logic [`RV_XLEN-1:0]       operand_b;
        rv_mem_op_e                mem_op;
        logic [`RV_XLEN-1:0]       store_data;  // rs2 value for SW
        logic [`RV_REG_AW-1:0]     rd;
        logic                      wb_en;
        logic                      wb_from_alu; // 0 = load data
    } rv_id_ex_t;

    // one register write request
    typedef struct packed {
        logic                      wb_en;
        logic [`RV_REG_AW-1:0]     rd;
        logic [`RV_XLEN-1:0]       data;
    } rv_wb_t;

    // data bus request from the memory stage
    typedef struct packed {
        logic                      read_wrn;    // 1 = read, 0 = write
        logic [`RV_DADDR_W-1:0]    addr;
        logic [`RV_XLEN-1:0]       wdata;
    } rv_dmem_req_t;

endpackage

/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// *******************************************************************
// core widths
// *******************************************************************

`define RV_XLEN       32            // data and instruction width
`define RV_REG_COUNT  32            // x0..x31
`define RV_REG_AW     5             // register index width
`define RV_DADDR_W    16            // data bus address width

// *******************************************************************
// fixed encodings
// *******************************************************************

// ADDI x0, x0, 0
`define RV_NOP        32'h0000_0013

`define RV_RESET_PC   32'h0000_0000 // first fetch address

`endif
